// ==== design/basics_pkg.sv ====
package basics_pkg;

	// Request command bytes
	localparam logic [7:0] CMD_VERSION    = 8'h76;
	localparam logic [7:0] CMD_I2C_QUERY  = 8'h49;
	localparam logic [7:0] CMD_I2C_SET    = 8'h69;
	localparam logic [7:0] CMD_GPIO_QUERY = 8'h47;
	localparam logic [7:0] CMD_GPIO_SET   = 8'h67;

	// Selector bytes, ASCII letters on the bus
	localparam logic [7:0] SEL_I2C_SPEED  = 8'h63;
	localparam logic [7:0] SEL_I2C_ADDR   = 8'h61;
	localparam logic [7:0] SEL_GPIO_LEVEL = 8'h6c;
	localparam logic [7:0] SEL_GPIO_DIR   = 8'h64;

	// First byte of every response frame
	localparam logic [7:0] RESP_ACK = 8'h01;
	localparam logic [7:0] RESP_NAK = 8'h00;

	localparam logic [7:0] VERSION_MAJOR = 8'h00;
	localparam logic [7:0] VERSION_MINOR = 8'h03;

	localparam logic [7:0]  I2C_SPEED_RESET = 8'd99;
	localparam logic [15:0] I2C_ADDR_RESET  = 16'hFFFF;

	localparam int GPIO_WIDTH = 24;

	// Engine states
	localparam logic [2:0] ST_IDLE        = 3'd0;
	localparam logic [2:0] ST_SELECT      = 3'd1;
	localparam logic [2:0] ST_VER_COLLECT = 3'd2;
	localparam logic [2:0] ST_SET_COLLECT = 3'd3;
	localparam logic [2:0] ST_RESPOND     = 3'd4;
	localparam logic [2:0] ST_WAIT        = 3'd5;
	localparam logic [2:0] ST_APPLY       = 3'd6;

	// Setting addressed by the selector
	localparam logic [2:0] TGT_NONE       = 3'd0;
	localparam logic [2:0] TGT_I2C_SPEED  = 3'd1;
	localparam logic [2:0] TGT_I2C_ADDR   = 3'd2;
	localparam logic [2:0] TGT_GPIO_LEVEL = 3'd3;
	localparam logic [2:0] TGT_GPIO_DIR   = 3'd4;

	// Request header position
	localparam logic [1:0] HDR_IDLE = 2'd0;
	localparam logic [1:0] HDR_EID  = 2'd1;
	localparam logic [1:0] HDR_LEN  = 2'd2;
	localparam logic [1:0] HDR_BODY = 2'd3;

	// Response byte position
	localparam logic [1:0] IDX_LEAD = 2'd0;
	localparam logic [1:0] IDX_CODE = 2'd1;
	localparam logic [1:0] IDX_EID  = 2'd2;
	localparam logic [1:0] IDX_PAY  = 2'd3;

	// One parameter word, as a number or as bytes with bytes[2] on top
	typedef union packed {
		logic [GPIO_WIDTH-1:0] value;
		logic [2:0][7:0]       bytes;
	} param_word_u;

endpackage

// ==== design/cmd_if.sv ====
interface cmd_if ();

	logic       cmd_start;
	logic [7:0] cmd_code;
	logic [7:0] eid;
	// Selector and data bytes after the length byte
	logic       body_valid;
	logic [7:0] body_data;
	logic       frame_end;

	modport source (
		output cmd_start, cmd_code, eid, body_valid, body_data, frame_end
	);

	modport sink (
		input cmd_start, cmd_code, eid, body_valid, body_data, frame_end
	);

endinterface

// ==== design/resp_if.sv ====
interface resp_if
	import basics_pkg::*;
();

	logic        start;
	logic [7:0]  code;
	logic [7:0]  eid;
	// Number of payload bytes, zero to three
	logic [1:0]  payload_len;
	param_word_u payload;
	// Driven back by the framer
	logic        busy;

	modport source (
		output start, code, eid, payload_len, payload,
		input  busy
	);

	modport sink (
		input  start, code, eid, payload_len, payload,
		output busy
	);

endinterface

// ==== design/frame_parser.sv ====
module frame_parser
	import basics_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] ma_data,
	input  logic       ma_data_valid,
	input  logic       ma_frame_valid,
	cmd_if.source      cmd
);

	logic       prev_frame;
	logic [1:0] hdr_cnt;
	logic       byte_in;
	logic       first_byte;

	assign byte_in    = ma_data_valid && ma_frame_valid;
	// Command byte arrives together with the rising frame level
	assign first_byte = byte_in && !prev_frame;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prev_frame     <= 1'b0;
			hdr_cnt        <= HDR_IDLE;
			cmd.cmd_start  <= 1'b0;
			cmd.body_valid <= 1'b0;
			cmd.frame_end  <= 1'b0;
		end else begin
			prev_frame     <= ma_frame_valid;
			cmd.cmd_start  <= first_byte;
			cmd.body_valid <= byte_in && !first_byte && (hdr_cnt == HDR_BODY);
			cmd.frame_end  <= prev_frame && !ma_frame_valid;

			if (!ma_frame_valid) begin
				hdr_cnt <= HDR_IDLE;
			end else if (first_byte) begin
				hdr_cnt <= HDR_EID;
			end else if (byte_in) begin
				case (hdr_cnt)
					HDR_EID: hdr_cnt <= HDR_LEN;
					// Length byte is not used
					HDR_LEN: hdr_cnt <= HDR_BODY;
					default: hdr_cnt <= hdr_cnt;
				endcase
			end
		end
	end

	// Byte fields, qualified by the strobes above
	always_ff @(posedge clk) begin
		if (first_byte) begin
			cmd.cmd_code <= ma_data;
		end
		if (byte_in && !first_byte && (hdr_cnt == HDR_EID)) begin
			cmd.eid <= ma_data;
		end
		if (byte_in && !first_byte && (hdr_cnt == HDR_BODY)) begin
			cmd.body_data <= ma_data;
		end
	end

endmodule

// ==== design/command_engine.sv ====
module command_engine
	import basics_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	cmd_if.sink                   cmd,
	resp_if.source                resp,
	input  logic [GPIO_WIDTH-1:0] gpio_read,
	output logic [7:0]            i2c_speed,
	output logic [15:0]           i2c_addr,
	output logic [GPIO_WIDTH-1:0] gpio_level,
	output logic [GPIO_WIDTH-1:0] gpio_direction
);

	logic [2:0]  state;
	logic        fam_gpio;
	logic        fam_set;
	logic [2:0]  target;
	logic [1:0]  byte_cnt;
	logic [7:0]  resp_code;
	logic [1:0]  resp_len;
	param_word_u resp_word;
	param_word_u stage;
	logic [7:0]  ver_first;

	logic [2:0]            sel_target;
	logic [1:0]            sel_len;
	logic [GPIO_WIDTH-1:0] sel_value;
	logic                  sel_hit;
	logic                  ver_byte;
	logic                  set_byte;
	logic                  last_byte;
	logic                  ver_match;

	// Selector decode within the latched command family
	always_comb begin
		sel_target = TGT_NONE;
		sel_len    = 2'd0;
		sel_value  = '0;
		if (fam_gpio) begin
			if (cmd.body_data == SEL_GPIO_LEVEL) begin
				sel_target = TGT_GPIO_LEVEL;
				sel_len    = 2'd3;
				// Level query reports the pins, not the driven level
				sel_value  = gpio_read;
			end else if (cmd.body_data == SEL_GPIO_DIR) begin
				sel_target = TGT_GPIO_DIR;
				sel_len    = 2'd3;
				sel_value  = gpio_direction;
			end
		end else begin
			if (cmd.body_data == SEL_I2C_SPEED) begin
				sel_target = TGT_I2C_SPEED;
				sel_len    = 2'd1;
				sel_value  = {16'h0000, i2c_speed};
			end else if (cmd.body_data == SEL_I2C_ADDR) begin
				sel_target = TGT_I2C_ADDR;
				sel_len    = 2'd2;
				sel_value  = {8'h00, i2c_addr};
			end
		end
	end

	assign sel_hit   = (state == ST_SELECT) && cmd.body_valid && (sel_target != TGT_NONE);
	assign ver_byte  = (state == ST_VER_COLLECT) && cmd.body_valid;
	assign set_byte  = (state == ST_SET_COLLECT) && cmd.body_valid;
	assign last_byte = (byte_cnt == 2'd1);
	assign ver_match = ({ver_first, cmd.body_data} == {VERSION_MAJOR, VERSION_MINOR});

	assign resp.start       = (state == ST_RESPOND);
	assign resp.code        = resp_code;
	assign resp.eid         = cmd.eid;
	assign resp.payload_len = resp_len;
	assign resp.payload     = resp_word;

	// Payload words, right aligned so the framer sends the low bytes
	always_ff @(posedge clk) begin
		if (sel_hit && !fam_set) begin
			resp_word.value <= sel_value;
		end else if (ver_byte && last_byte) begin
			resp_word.value <= {8'h00, VERSION_MAJOR, VERSION_MINOR};
		end
		if (ver_byte) begin
			ver_first <= cmd.body_data;
		end
		if (set_byte) begin
			stage.bytes <= {stage.bytes[1:0], cmd.body_data};
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state          <= ST_IDLE;
			fam_gpio       <= 1'b0;
			fam_set        <= 1'b0;
			target         <= TGT_NONE;
			byte_cnt       <= 2'd0;
			resp_code      <= RESP_NAK;
			resp_len       <= 2'd0;
			i2c_speed      <= I2C_SPEED_RESET;
			i2c_addr       <= I2C_ADDR_RESET;
			gpio_level     <= '0;
			gpio_direction <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (cmd.cmd_start) begin
						fam_gpio <= (cmd.cmd_code == CMD_GPIO_QUERY) ||
							(cmd.cmd_code == CMD_GPIO_SET);
						fam_set  <= (cmd.cmd_code == CMD_I2C_SET) ||
							(cmd.cmd_code == CMD_GPIO_SET);
						case (cmd.cmd_code)
							CMD_VERSION: begin
								byte_cnt <= 2'd2;
								state    <= ST_VER_COLLECT;
							end
							CMD_I2C_QUERY, CMD_I2C_SET, CMD_GPIO_QUERY, CMD_GPIO_SET: begin
								state <= ST_SELECT;
							end
							// Unknown commands are dropped silently
							default: state <= ST_IDLE;
						endcase
					end
				end
				ST_SELECT: begin
					if (cmd.body_valid) begin
						target <= sel_target;
						if (sel_target == TGT_NONE) begin
							state <= ST_IDLE;
						end else if (fam_set) begin
							byte_cnt <= sel_len;
							state    <= ST_SET_COLLECT;
						end else begin
							resp_code <= RESP_ACK;
							resp_len  <= sel_len;
							state     <= ST_RESPOND;
						end
					end else if (cmd.frame_end) begin
						state <= ST_IDLE;
					end
				end
				ST_VER_COLLECT: begin
					if (cmd.body_valid) begin
						byte_cnt <= byte_cnt - 2'd1;
						if (last_byte) begin
							resp_code <= ver_match ? RESP_ACK : RESP_NAK;
							resp_len  <= ver_match ? 2'd0 : 2'd2;
							state     <= ST_RESPOND;
						end
					end else if (cmd.frame_end) begin
						state <= ST_IDLE;
					end
				end
				ST_SET_COLLECT: begin
					if (cmd.body_valid) begin
						// I2C settings take each byte as it arrives
						case (target)
							TGT_I2C_SPEED: i2c_speed <= cmd.body_data;
							TGT_I2C_ADDR:  i2c_addr  <= {i2c_addr[7:0], cmd.body_data};
							default:       i2c_speed <= i2c_speed;
						endcase
						byte_cnt <= byte_cnt - 2'd1;
						if (last_byte) begin
							resp_code <= RESP_ACK;
							resp_len  <= 2'd0;
							state     <= ST_RESPOND;
						end
					end else if (cmd.frame_end) begin
						state <= ST_IDLE;
					end
				end
				ST_RESPOND: begin
					state <= ST_WAIT;
				end
				ST_WAIT: begin
					// GPIO changes only once the response is out
					if (!resp.busy) begin
						if (fam_set && (target == TGT_GPIO_LEVEL)) begin
							gpio_level <= stage.value;
						end
						if (fam_set && (target == TGT_GPIO_DIR)) begin
							gpio_direction <= stage.value;
						end
						state <= ST_APPLY;
					end
				end
				ST_APPLY: begin
					target <= TGT_NONE;
					state  <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== design/response_framer.sv ====
module response_framer
	import basics_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	resp_if.sink       resp,
	output logic [7:0] resp_data,
	output logic       resp_valid,
	output logic       resp_frame
);

	logic [1:0]  idx;
	logic [1:0]  rem;
	logic [1:0]  pay_sel;
	logic [7:0]  code_q;
	logic [7:0]  eid_q;
	param_word_u word_q;

	assign resp.busy = resp.start || resp_frame;

	// Lead cycle with the frame level up and no data
	assign resp_valid = resp_frame && (idx != IDX_LEAD);
	assign pay_sel    = rem - 2'd1;

	always_comb begin
		case (idx)
			IDX_CODE: resp_data = code_q;
			IDX_EID:  resp_data = eid_q;
			IDX_PAY:  resp_data = word_q.bytes[pay_sel];
			default:  resp_data = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (resp.start && !resp_frame) begin
			code_q <= resp.code;
			eid_q  <= resp.eid;
			word_q <= resp.payload;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			resp_frame <= 1'b0;
			idx        <= IDX_LEAD;
			rem        <= 2'd0;
		end else if (!resp_frame) begin
			if (resp.start) begin
				resp_frame <= 1'b1;
				idx        <= IDX_LEAD;
				rem        <= resp.payload_len;
			end
		end else begin
			case (idx)
				IDX_LEAD: idx <= IDX_CODE;
				IDX_CODE: idx <= IDX_EID;
				IDX_EID: begin
					if (rem == 2'd0)
						resp_frame <= 1'b0;
					else
						idx <= IDX_PAY;
				end
				default: begin
					// Payload goes out most significant byte first
					rem <= rem - 2'd1;
					if (rem == 2'd1)
						resp_frame <= 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== design/basics_top.sv ====
module basics_top
	import basics_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [7:0]            ma_data,
	input  logic                  ma_data_valid,
	input  logic                  ma_frame_valid,
	input  logic [GPIO_WIDTH-1:0] gpio_read,
	output logic [7:0]            resp_data,
	output logic                  resp_valid,
	output logic                  resp_frame,
	output logic [7:0]            i2c_speed,
	output logic [15:0]           i2c_addr,
	output logic [GPIO_WIDTH-1:0] gpio_level,
	output logic [GPIO_WIDTH-1:0] gpio_direction
);

	cmd_if  cmd_bus ();
	resp_if resp_bus ();

	frame_parser u_parser (
		.clk            (clk),
		.rst            (rst),
		.ma_data        (ma_data),
		.ma_data_valid  (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.cmd            (cmd_bus.source)
	);

	command_engine u_engine (
		.clk            (clk),
		.rst            (rst),
		.cmd            (cmd_bus.sink),
		.resp           (resp_bus.source),
		.gpio_read      (gpio_read),
		.i2c_speed      (i2c_speed),
		.i2c_addr       (i2c_addr),
		.gpio_level     (gpio_level),
		.gpio_direction (gpio_direction)
	);

	response_framer u_framer (
		.clk        (clk),
		.rst        (rst),
		.resp       (resp_bus.sink),
		.resp_data  (resp_data),
		.resp_valid (resp_valid),
		.resp_frame (resp_frame)
	);

endmodule

// ==== verif/basics_assert.sv ====
module basics_assert
	import basics_pkg::*;
(
	input logic                  clk,
	input logic                  rst,
	input logic [7:0]            ma_data,
	input logic                  ma_data_valid,
	input logic                  ma_frame_valid,
	input logic [GPIO_WIDTH-1:0] gpio_read,
	input logic [7:0]            resp_data,
	input logic                  resp_valid,
	input logic                  resp_frame,
	input logic [7:0]            i2c_speed,
	input logic [15:0]           i2c_addr,
	input logic [GPIO_WIDTH-1:0] gpio_level,
	input logic [GPIO_WIDTH-1:0] gpio_direction
);

	int fail_count = 0;

	logic                  prev_frame;
	logic                  prev_resp;
	logic [2:0]            req_pos;
	logic [7:0]            req_cmd;
	logic [7:0]            req_eid;
	logic [7:0]            req_sel;
	logic [23:0]           req_data;
	logic [15:0]           addr_model;
	logic [2:0]            rsp_idx;
	logic [7:0]            exp_code;
	logic [1:0]            exp_plen;
	logic [GPIO_WIDTH-1:0] exp_word;
	logic [GPIO_WIDTH-1:0] shifted;
	logic [2:0]            pay_pos;
	logic [7:0]            exp_byte;

	// Request fields and response byte count, taken from the bus pins
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prev_frame <= 1'b0;
			prev_resp  <= 1'b0;
			req_pos    <= 3'd0;
			req_cmd    <= 8'h00;
			req_eid    <= 8'h00;
			req_sel    <= 8'h00;
			req_data   <= '0;
			addr_model <= I2C_ADDR_RESET;
			rsp_idx    <= 3'd0;
		end else begin
			prev_frame <= ma_frame_valid;
			prev_resp  <= resp_frame;
			if (!resp_frame)
				rsp_idx <= 3'd0;
			else if (resp_valid)
				rsp_idx <= rsp_idx + 3'd1;
			// Address setting seen by later queries
			if (prev_resp && !resp_frame && req_cmd == CMD_I2C_SET && req_sel == SEL_I2C_ADDR)
				addr_model <= req_data[15:0];
			if (ma_frame_valid && ma_data_valid) begin
				if (!prev_frame) begin
					req_cmd  <= ma_data;
					req_pos  <= 3'd1;
					req_sel  <= 8'h00;
					req_data <= '0;
				end else begin
					if (req_pos != 3'd4)
						req_pos <= req_pos + 3'd1;
					if (req_pos == 3'd1)
						req_eid <= ma_data;
					else if (req_pos == 3'd3 && req_cmd != CMD_VERSION)
						req_sel <= ma_data;
					else if (req_pos >= 3'd3)
						req_data <= {req_data[15:0], ma_data};
				end
			end
		end
	end

	// Expected response byte at the current position
	always_comb begin
		exp_code = RESP_ACK;
		exp_plen = 2'd0;
		exp_word = '0;
		// Own version is major 0x00, minor 0x03
		if (req_cmd == CMD_VERSION && req_data[15:0] != 16'h0003) begin
			exp_code = RESP_NAK;
			exp_plen = 2'd2;
			exp_word = 24'h000003;
		end else if (req_cmd == CMD_I2C_QUERY && req_sel == SEL_I2C_ADDR) begin
			exp_plen = 2'd2;
			exp_word = {8'h00, addr_model};
		end else if (req_cmd == CMD_GPIO_QUERY && req_sel == SEL_GPIO_LEVEL) begin
			exp_plen = 2'd3;
			exp_word = gpio_read;
		end
		// Most significant payload byte goes first
		pay_pos = {1'b0, exp_plen} + 3'd1 - rsp_idx;
		shifted = exp_word >> {pay_pos, 3'b000};
		case (rsp_idx)
			3'd0:    exp_byte = exp_code;
			3'd1:    exp_byte = req_eid;
			default: exp_byte = shifted[7:0];
		endcase
	end

	reset_state: assert property (@(posedge clk) $fell(rst) |-> !resp_frame && !resp_valid &&
		i2c_speed == I2C_SPEED_RESET && i2c_addr == I2C_ADDR_RESET &&
		gpio_level == '0 && gpio_direction == '0)
	else begin
		$error("FAILED reset state: resp_frame=%h resp_valid=%h i2c_speed=%h i2c_addr=%h",
			$sampled(resp_frame), $sampled(resp_valid), $sampled(i2c_speed),
			$sampled(i2c_addr));
		fail_count = fail_count + 1;
	end

	valid_in_frame: assert property (@(posedge clk) disable iff (rst) resp_valid |-> resp_frame)
	else begin
		$error("resp_valid went high outside a response frame");
		fail_count = fail_count + 1;
	end

	resp_byte: assert property (@(posedge clk) disable iff (rst)
		resp_valid |-> resp_data == exp_byte)
	else begin
		$error("FAILED resp_data: got %h, expected %h", $sampled(resp_data), $sampled(exp_byte));
		fail_count = fail_count + 1;
	end

	resp_length: assert property (@(posedge clk) disable iff (rst)
		$fell(resp_frame) |-> rsp_idx == {1'b0, exp_plen} + 3'd2)
	else begin
		$error("FAILED response length: got %h bytes, expected %h",
			$sampled(rsp_idx), $sampled(exp_plen) + 3'd2);
		fail_count = fail_count + 1;
	end

	addr_set: assert property (@(posedge clk) disable iff (rst)
		$fell(resp_frame) && req_cmd == CMD_I2C_SET && req_sel == SEL_I2C_ADDR
		|-> i2c_addr == req_data[15:0])
	else begin
		$error("FAILED i2c_addr: got %h, expected %h", $sampled(i2c_addr),
			$sampled(req_data[15:0]));
		fail_count = fail_count + 1;
	end

	dir_held: assert property (@(posedge clk) disable iff (rst)
		resp_frame |-> $stable(gpio_direction))
	else begin
		$error("FAILED gpio_direction: got %h, expected %h", $sampled(gpio_direction),
			$past(gpio_direction));
		fail_count = fail_count + 1;
	end

	dir_applied: assert property (@(posedge clk) disable iff (rst)
		$fell(resp_frame) && req_cmd == CMD_GPIO_SET && req_sel == SEL_GPIO_DIR
		|=> gpio_direction == req_data)
	else begin
		$error("FAILED gpio_direction: got %h, expected %h", $sampled(gpio_direction),
			$sampled(req_data));
		fail_count = fail_count + 1;
	end

endmodule

// ==== verif/tb_basics.sv ====
module tb_basics
	import basics_pkg::*;
();

	localparam int NUM_TESTS   = 7;
	localparam int TEST_CYCLES = 60;
	// Run length with a wide margin
	localparam int MAX_CYCLES  = NUM_TESTS * TEST_CYCLES * 5;

	logic                  clk;
	logic                  rst;
	logic [7:0]            ma_data;
	logic                  ma_data_valid;
	logic                  ma_frame_valid;
	logic [GPIO_WIDTH-1:0] gpio_read;
	logic [7:0]            resp_data;
	logic                  resp_valid;
	logic                  resp_frame;
	logic [7:0]            i2c_speed;
	logic [15:0]           i2c_addr;
	logic [GPIO_WIDTH-1:0] gpio_level;
	logic [GPIO_WIDTH-1:0] gpio_direction;

	logic [31:0] lfsr;
	logic [7:0]  frame_q[$];
	logic [7:0]  eid;
	logic [7:0]  b0;
	logic [7:0]  b1;
	logic [7:0]  b2;
	int          cycle_count = 0;
	int          tests_run;
	int          fails_before;

	basics_top UUT (
		.clk            (clk),
		.rst            (rst),
		.ma_data        (ma_data),
		.ma_data_valid  (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.gpio_read      (gpio_read),
		.resp_data      (resp_data),
		.resp_valid     (resp_valid),
		.resp_frame     (resp_frame),
		.i2c_speed      (i2c_speed),
		.i2c_addr       (i2c_addr),
		.gpio_level     (gpio_level),
		.gpio_direction (gpio_direction)
	);

	bind basics_top basics_assert u_assert (
		.clk            (clk),
		.rst            (rst),
		.ma_data        (ma_data),
		.ma_data_valid  (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.gpio_read      (gpio_read),
		.resp_data      (resp_data),
		.resp_valid     (resp_valid),
		.resp_frame     (resp_frame),
		.i2c_speed      (i2c_speed),
		.i2c_addr       (i2c_addr),
		.gpio_level     (gpio_level),
		.gpio_direction (gpio_direction)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: no end of test after %0d cycles", MAX_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	// Galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		b = 8'h00;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic send_frame();
		foreach (frame_q[i]) begin
			@(posedge clk);
			ma_frame_valid <= 1'b1;
			ma_data_valid  <= 1'b1;
			ma_data        <= frame_q[i];
		end
		@(posedge clk);
		ma_frame_valid <= 1'b0;
		ma_data_valid  <= 1'b0;
		ma_data        <= 8'h00;
		frame_q.delete();
	endtask

	// Engine needs a few cycles after the frame to get back to idle
	task automatic wait_response();
		while (!resp_frame)
			@(posedge clk);
		while (resp_frame)
			@(posedge clk);
		repeat (3) @(posedge clk);
	endtask

	task automatic end_test(input string name);
		tests_run = tests_run + 1;
		$display("test %0d %s done, %0d assertion failures", tests_run, name,
			UUT.u_assert.fail_count - fails_before);
		fails_before = UUT.u_assert.fail_count;
	endtask

	task automatic exchange(input string name);
		send_frame();
		wait_response();
		end_test(name);
	endtask

	initial begin
		rst            = 1'b1;
		ma_data        = 8'h00;
		ma_data_valid  = 1'b0;
		ma_frame_valid = 1'b0;
		gpio_read      = '0;
		lfsr           = 32'h2f81fa13;
		tests_run      = 0;
		fails_before   = 0;

		repeat (4) @(posedge clk);
		rst <= 1'b0;
		repeat (3) @(posedge clk);
		end_test("reset_state");

		rand_byte(eid);
		frame_q = {CMD_VERSION, eid, 8'h02, 8'h00, 8'h03};
		exchange("version_match");

		// Top bit set so the minor byte never matches
		rand_byte(eid);
		rand_byte(b0);
		rand_byte(b1);
		b1 = b1 | 8'h80;
		frame_q = {CMD_VERSION, eid, 8'h02, b0, b1};
		exchange("version_mismatch");

		rand_byte(eid);
		rand_byte(b0);
		rand_byte(b1);
		frame_q = {CMD_I2C_SET, eid, 8'h03, SEL_I2C_ADDR, b0, b1};
		exchange("i2c_addr_set");

		rand_byte(eid);
		frame_q = {CMD_I2C_QUERY, eid, 8'h01, SEL_I2C_ADDR};
		exchange("i2c_addr_query");

		rand_byte(eid);
		rand_byte(b0);
		rand_byte(b1);
		rand_byte(b2);
		frame_q = {CMD_GPIO_SET, eid, 8'h04, SEL_GPIO_DIR, b0, b1, b2};
		exchange("gpio_dir_set");

		rand_byte(eid);
		rand_byte(b0);
		rand_byte(b1);
		rand_byte(b2);
		@(posedge clk);
		gpio_read <= {b0, b1, b2};
		frame_q = {CMD_GPIO_QUERY, eid, 8'h01, SEL_GPIO_LEVEL};
		exchange("gpio_level_query");

		$display("%0d tests run, %0d assertion failures", tests_run, UUT.u_assert.fail_count);
		if (UUT.u_assert.fail_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== filelist.f ====
design/basics_pkg.sv
design/cmd_if.sv
design/resp_if.sv
design/frame_parser.sv
design/command_engine.sv
design/response_framer.sv
design/basics_top.sv
verif/basics_assert.sv
verif/tb_basics.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module tb_basics -f filelist.f

# Error limit raised so a failing run still reaches its summary
run: compile
	@out="$$(./obj_dir/Vtb_basics +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
